/* design/sprite_geom_pkg.sv */
// Screen and sprite geometry for the sprite engine.
// Holds the line and sprite sizes, the position offsets used when the
// sprite list is decoded, and the attribute and pixel types shared by the
// copy stage, the render stage and the top level.

`default_nettype none

package sprite_geom_pkg;

    // ============================================================
    // geometry
    // ============================================================
    localparam int LINE_WIDTH   = 256;
    localparam int SPRITE_SIZE  = 16;
    localparam int SPRITE_COUNT = 64;

    // raw y byte is subtracted from this
    localparam int Y_BASE = 240;
    // taken off the 9-bit raw x
    localparam int X_BIAS = 128;

    // ============================================================
    // decoded sprite, one entry of the sprite buffer
    // ============================================================
    typedef struct packed {
        logic [8:0] tile;
        logic [8:0] x_pos;
        logic [7:0] y_pos;
        logic [3:0] colour;
        logic       flip_x;
        logic       flip_y;
        logic [2:0] spare;
    } sprite_attr_t;

    // line buffer entry, pen 0 is transparent
    typedef struct packed {
        logic [3:0] colour;
        logic [3:0] pen;
    } sprite_pix_t;

endpackage

`default_nettype wire

/* design/sprite_mem_pkg.sv */
// Memory layout for the sprite engine.
// Sizes and address types of the CPU-shared sprite RAM and the sprite
// graphics ROM, plus where each field sits in the 4-byte list entry.

`default_nettype none

package sprite_mem_pkg;

    localparam int SHARED_BYTES     = 256;
    localparam int BYTES_PER_SPRITE = 4;
    // 64 KB of sprite graphics
    localparam int GFX_ADDR_W       = 16;

    // byte offsets inside one list entry
    localparam logic [1:0] BYTE_Y     = 2'd0;
    localparam logic [1:0] BYTE_TILE  = 2'd1;
    localparam logic [1:0] BYTE_FLAGS = 2'd2;
    localparam logic [1:0] BYTE_X     = 2'd3;

    // flags byte, colour sits in bits 7 to 4
    localparam int FLAG_X256  = 0;
    localparam int FLAG_TILE8 = 1;
    localparam int FLAG_FLIPX = 2;
    localparam int FLAG_FLIPY = 3;

    typedef logic [7:0]            shared_addr_t;
    typedef logic [GFX_ADDR_W-1:0] gfx_addr_t;
    typedef logic [7:0]            byte_t;

endpackage

`default_nettype wire

/* design/sprite_ram.sv */
// Single-port-write, single-port-read synchronous RAM.
// The read data is registered, so it shows one cycle after rd_addr.
// entry_t picks the payload, DEPTH the number of entries.

`default_nettype none

module sprite_ram #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = 256
) (
    input  wire logic                     clk_sys,
    input  wire logic                     wr,
    input  wire logic [$clog2(DEPTH)-1:0] wr_addr,
    input  wire entry_t                   wr_data,
    input  wire logic [$clog2(DEPTH)-1:0] rd_addr,
    output entry_t                        rd_data
);

    entry_t mem [DEPTH];

    always_ff @(posedge clk_sys) begin
        if (wr) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

    // a write must land on a known entry
    wr_addr_known: assert property (@(posedge clk_sys) wr |-> !$isunknown(wr_addr))
        else $error("sprite_ram write with unknown address");

endmodule

`default_nettype wire

/* design/sprite_list_copy.sv */
// Sprite list copy stage.
// On vblank_start it reads all 256 bytes of the shared sprite RAM, one
// address per cycle, decodes each group of four bytes into an attribute
// word and writes it to the sprite buffer. copy_done pulses once the
// attribute of sprite 63 has been written.

`default_nettype none

module sprite_list_copy
    import sprite_geom_pkg::*;
    import sprite_mem_pkg::*;
(
    input  wire logic         clk_sys,
    input  wire logic         reset,
    input  wire logic         vblank_start,
    output shared_addr_t      shared_addr,
    input  wire byte_t        shared_data,
    output logic              buf_wr,
    output logic [5:0]        buf_idx,
    output sprite_attr_t      buf_attr,
    output logic              copy_done
);

    localparam int SEL_W = $clog2(BYTES_PER_SPRITE);

    logic         busy;
    logic         data_valid;
    shared_addr_t data_addr;
    byte_t        y_raw;
    byte_t        tile_lo;
    byte_t        flags;
    sprite_attr_t new_attr;

    // ============================================================
    // address walk
    // ============================================================
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            busy        <= 1'b0;
            data_valid  <= 1'b0;
            shared_addr <= '0;
        end else begin
            data_valid <= busy;
            if (vblank_start && !busy) begin
                busy        <= 1'b1;
                shared_addr <= '0;
            end else if (busy) begin
                if (shared_addr == shared_addr_t'(SHARED_BYTES - 1)) begin
                    busy <= 1'b0;
                end else begin
                    shared_addr <= shared_addr + 1'b1;
                end
            end
        end
    end

    // address that the returning byte belongs to
    always_ff @(posedge clk_sys) begin
        data_addr <= shared_addr;
    end

    // ============================================================
    // decode
    // ============================================================
    always_comb begin
        new_attr        = '0;
        new_attr.y_pos  = 8'(Y_BASE) - y_raw;
        new_attr.tile   = {flags[FLAG_TILE8], tile_lo};
        new_attr.x_pos  = {flags[FLAG_X256], shared_data} - 9'(X_BIAS);
        new_attr.colour = flags[7:4];
        new_attr.flip_x = flags[FLAG_FLIPX];
        new_attr.flip_y = flags[FLAG_FLIPY];
    end

    always_ff @(posedge clk_sys) begin
        if (data_valid) begin
            case (data_addr[SEL_W-1:0])
                BYTE_Y:     y_raw   <= shared_data;
                BYTE_TILE:  tile_lo <= shared_data;
                BYTE_FLAGS: flags   <= shared_data;
                BYTE_X: begin
                    buf_idx  <= data_addr[7:SEL_W];
                    buf_attr <= new_attr;
                end
            endcase
        end
    end

    // write strobe with the last byte, done one cycle after the final write
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            buf_wr    <= 1'b0;
            copy_done <= 1'b0;
        end else begin
            buf_wr    <= data_valid && (data_addr[SEL_W-1:0] == BYTE_X);
            copy_done <= buf_wr && (buf_idx == 6'(SPRITE_COUNT - 1));
        end
    end

    // the whole pipeline has to drain before the next vblank
    no_vblank_in_copy: assert property (@(posedge clk_sys) disable iff (reset)
        vblank_start |-> !(busy || data_valid || buf_wr))
        else $error("vblank_start during sprite list copy");

endmodule

`default_nettype wire

/* design/sprite_line_render.sv */
// Line render stage.
// On line_start it clears the 256-entry line buffer, then walks the 64
// sprites in index order, draws the 16 columns of each one that covers
// line_y and pulses line_done at the end. The line buffer is read back
// through pix_x, with pix_out one cycle later.

`default_nettype none

module sprite_line_render
    import sprite_geom_pkg::*;
    import sprite_mem_pkg::*;
(
    input  wire logic         clk_sys,
    input  wire logic         reset,
    input  wire logic         line_start,
    input  wire logic [7:0]   line_y,
    output logic [5:0]        buf_idx,
    input  wire sprite_attr_t buf_attr,
    output gfx_addr_t         gfx_addr,
    input  wire byte_t        gfx_data,
    input  wire logic [7:0]   pix_x,
    output sprite_pix_t       pix_out,
    output logic              line_done
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_CLEAR,
        S_FETCH,
        S_ATTR,
        S_COL,
        S_PIX,
        S_NEXT
    } state_t;

    state_t       state;
    logic [7:0]   line_q;
    logic [7:0]   clr_x;
    logic [3:0]   col;
    logic [3:0]   fy_q;
    sprite_attr_t attr_q;
    logic [7:0]   row;
    logic [3:0]   fx;
    logic [8:0]   draw_x;
    logic [3:0]   pen;
    logic         lb_wr;
    logic [7:0]   lb_addr;
    sprite_pix_t  lb_data;

    // ============================================================
    // sequencing
    // ============================================================
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state     <= S_IDLE;
            buf_idx   <= '0;
            line_done <= 1'b0;
        end else begin
            line_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (line_start) begin
                        state <= S_CLEAR;
                    end
                end
                S_CLEAR: begin
                    if (clr_x == 8'(LINE_WIDTH - 1)) begin
                        buf_idx <= '0;
                        state   <= S_FETCH;
                    end
                end
                // sprite buffer read in flight
                S_FETCH: state <= S_ATTR;
                S_ATTR: begin
                    if (row < 8'(SPRITE_SIZE) && buf_attr.x_pos < 9'(LINE_WIDTH)) begin
                        state <= S_COL;
                    end else begin
                        state <= S_NEXT;
                    end
                end
                // rom read in flight
                S_COL: state <= S_PIX;
                S_PIX: begin
                    if (col == 4'(SPRITE_SIZE - 1)) begin
                        state <= S_NEXT;
                    end else begin
                        state <= S_COL;
                    end
                end
                S_NEXT: begin
                    if (buf_idx == 6'(SPRITE_COUNT - 1)) begin
                        line_done <= 1'b1;
                        state     <= S_IDLE;
                    end else begin
                        buf_idx <= buf_idx + 1'b1;
                        state   <= S_FETCH;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // counters and latched sprite
    always_ff @(posedge clk_sys) begin
        if (state == S_IDLE && line_start) begin
            line_q <= line_y;
            clr_x  <= '0;
        end
        if (state == S_CLEAR) begin
            clr_x <= clr_x + 1'b1;
        end
        if (state == S_ATTR) begin
            attr_q <= buf_attr;
            col    <= '0;
            fy_q   <= buf_attr.flip_y ? ~row[3:0] : row[3:0];
        end
        if (state == S_PIX) begin
            col <= col + 1'b1;
        end
    end

    // ============================================================
    // pixel path
    // ============================================================
    assign row      = line_q - buf_attr.y_pos;
    assign fx       = attr_q.flip_x ? ~col : col;
    assign gfx_addr = {fx[1], attr_q.tile, fy_q, fx[3:2]};
    assign pen      = fx[0] ? gfx_data[7:4] : gfx_data[3:0];
    assign draw_x   = attr_q.x_pos + {5'd0, col};

    // clear writes zero, drawing skips clear pens and clipped columns
    always_comb begin
        if (state == S_CLEAR) begin
            lb_wr   = 1'b1;
            lb_addr = clr_x;
            lb_data = '0;
        end else begin
            lb_wr   = (state == S_PIX) && (pen != 4'd0) && (draw_x < 9'(LINE_WIDTH));
            lb_addr = draw_x[7:0];
            lb_data = '{colour: attr_q.colour, pen: pen};
        end
    end

    sprite_ram #(
        .entry_t (sprite_pix_t),
        .DEPTH   (LINE_WIDTH)
    ) u_line_buf (
        .clk_sys (clk_sys),
        .wr      (lb_wr),
        .wr_addr (lb_addr),
        .wr_data (lb_data),
        .rd_addr (pix_x),
        .rd_data (pix_out)
    );

    no_line_start_busy: assert property (@(posedge clk_sys) disable iff (reset)
        line_start |-> state == S_IDLE)
        else $error("line_start while a line is rendering");

endmodule

`default_nettype wire

/* design/sprite_engine.sv */
// Sprite engine top level.
// Joins the CPU-shared sprite RAM, the sprite graphics ROM and the sprite
// buffer to the list copy stage and the line render stage. The CPU and
// download ports load the two memories, the strobes start copy and render.

`default_nettype none

module sprite_engine
    import sprite_geom_pkg::*;
    import sprite_mem_pkg::*;
(
    input  wire logic         clk_sys,
    input  wire logic         reset,
    input  wire logic         cpu_wr,
    input  wire shared_addr_t cpu_addr,
    input  wire byte_t        cpu_data,
    input  wire logic         rom_wr,
    input  wire gfx_addr_t    rom_addr,
    input  wire byte_t        rom_data,
    input  wire logic         vblank_start,
    input  wire logic         line_start,
    input  wire logic [7:0]   line_y,
    input  wire logic [7:0]   pix_x,
    output logic              copy_done,
    output logic              line_done,
    output sprite_pix_t       pix_out
);

    shared_addr_t shared_rd_addr;
    byte_t        shared_rd_data;
    gfx_addr_t    gfx_rd_addr;
    byte_t        gfx_rd_data;
    logic         buf_wr;
    logic [5:0]   buf_wr_idx;
    sprite_attr_t buf_wr_attr;
    logic [5:0]   buf_rd_idx;
    sprite_attr_t buf_rd_attr;

    // ============================================================
    // memories
    // ============================================================
    sprite_ram #(.entry_t(byte_t), .DEPTH(SHARED_BYTES)) u_shared_ram (
        .clk_sys (clk_sys),
        .wr      (cpu_wr),
        .wr_addr (cpu_addr),
        .wr_data (cpu_data),
        .rd_addr (shared_rd_addr),
        .rd_data (shared_rd_data)
    );

    sprite_ram #(.entry_t(byte_t), .DEPTH(1 << GFX_ADDR_W)) u_gfx_rom (
        .clk_sys (clk_sys),
        .wr      (rom_wr),
        .wr_addr (rom_addr),
        .wr_data (rom_data),
        .rd_addr (gfx_rd_addr),
        .rd_data (gfx_rd_data)
    );

    // decoded list, written by copy and read by render
    sprite_ram #(.entry_t(sprite_attr_t), .DEPTH(SPRITE_COUNT)) u_sprite_buf (
        .clk_sys (clk_sys),
        .wr      (buf_wr),
        .wr_addr (buf_wr_idx),
        .wr_data (buf_wr_attr),
        .rd_addr (buf_rd_idx),
        .rd_data (buf_rd_attr)
    );

    // ============================================================
    // stages
    // ============================================================
    sprite_list_copy u_copy (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .vblank_start (vblank_start),
        .shared_addr  (shared_rd_addr),
        .shared_data  (shared_rd_data),
        .buf_wr       (buf_wr),
        .buf_idx      (buf_wr_idx),
        .buf_attr     (buf_wr_attr),
        .copy_done    (copy_done)
    );

    sprite_line_render u_render (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .line_start (line_start),
        .line_y     (line_y),
        .buf_idx    (buf_rd_idx),
        .buf_attr   (buf_rd_attr),
        .gfx_addr   (gfx_rd_addr),
        .gfx_data   (gfx_rd_data),
        .pix_x      (pix_x),
        .pix_out    (pix_out),
        .line_done  (line_done)
    );

endmodule

`default_nettype wire

/* sim/tb_sprite_engine.sv */
// Testbench for the sprite engine top level.
// Replays the records of sim/sprite_patterns.mem: memory loads, vblank and
// line commands, expected pixels read back through pix_x, and test ends.
// Run from the project root so that the patterns file is found.

`default_nettype none

module tb_sprite_engine
    import sprite_geom_pkg::*;
    import sprite_mem_pkg::*;
();

    localparam int RECORD_MAX   = 256;
    localparam int COPY_LIMIT   = 600;
    localparam int RENDER_LIMIT = 3000;

    // record opcodes, top nibble of each word
    localparam logic [3:0] OP_END      = 4'h0;
    localparam logic [3:0] OP_RAM_WR   = 4'h1;
    localparam logic [3:0] OP_ROM_WR   = 4'h2;
    localparam logic [3:0] OP_CLEAR    = 4'h3;
    localparam logic [3:0] OP_VBLANK   = 4'h4;
    localparam logic [3:0] OP_LINE     = 4'h5;
    localparam logic [3:0] OP_PIXEL    = 4'h6;
    localparam logic [3:0] OP_TEST_END = 4'h7;
    localparam logic [3:0] OP_LIST_Y   = 4'h8;

    logic         clk_sys = 1'b0;
    logic         reset;
    logic         cpu_wr;
    shared_addr_t cpu_addr;
    byte_t        cpu_data;
    logic         rom_wr;
    gfx_addr_t    rom_addr;
    byte_t        rom_data;
    logic         vblank_start;
    logic         line_start;
    logic [7:0]   line_y;
    logic [7:0]   pix_x;
    logic         copy_done;
    logic         line_done;
    sprite_pix_t  pix_out;

    logic [31:0]  records [RECORD_MAX];
    int           test_errors;
    int           tests_passed;
    int           tests_failed;
    logic         timed_out;

    always #20 clk_sys = ~clk_sys;

    sprite_engine UUT (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .cpu_wr       (cpu_wr),
        .cpu_addr     (cpu_addr),
        .cpu_data     (cpu_data),
        .rom_wr       (rom_wr),
        .rom_addr     (rom_addr),
        .rom_data     (rom_data),
        .vblank_start (vblank_start),
        .line_start   (line_start),
        .line_y       (line_y),
        .pix_x        (pix_x),
        .copy_done    (copy_done),
        .line_done    (line_done),
        .pix_out      (pix_out)
    );

    // ============================================================
    // checking
    // ============================================================
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic finish_test(input int number);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0d passed", number);
        end else begin
            tests_failed++;
            $display("test %0d failed with %0d errors", number, test_errors);
        end
        test_errors = 0;
    endtask

    // ============================================================
    // host ports and strobes
    // ============================================================
    task automatic write_shared(input shared_addr_t addr, input byte_t data);
        @(posedge clk_sys);
        cpu_wr   <= 1'b1;
        cpu_addr <= addr;
        cpu_data <= data;
        @(posedge clk_sys);
        cpu_wr   <= 1'b0;
    endtask

    task automatic write_rom(input gfx_addr_t addr, input byte_t data);
        @(posedge clk_sys);
        rom_wr   <= 1'b1;
        rom_addr <= addr;
        rom_data <= data;
        @(posedge clk_sys);
        rom_wr   <= 1'b0;
    endtask

    task automatic clear_shared();
        int a;
        for (a = 0; a < SHARED_BYTES; a++) begin
            write_shared(shared_addr_t'(a), 8'h00);
        end
    endtask

    task automatic run_copy();
        int cycles;
        @(posedge clk_sys);
        vblank_start <= 1'b1;
        @(posedge clk_sys);
        vblank_start <= 1'b0;
        cycles = 0;
        @(negedge clk_sys);
        while (!copy_done && cycles < COPY_LIMIT) begin
            @(negedge clk_sys);
            cycles++;
        end
        if (!copy_done) begin
            $display("copy_done did not arrive within %0d cycles", COPY_LIMIT);
            timed_out = 1'b1;
        end
    endtask

    task automatic run_line(input logic [7:0] y);
        int cycles;
        @(posedge clk_sys);
        line_start <= 1'b1;
        line_y     <= y;
        @(posedge clk_sys);
        line_start <= 1'b0;
        cycles = 0;
        @(negedge clk_sys);
        while (!line_done && cycles < RENDER_LIMIT) begin
            @(negedge clk_sys);
            cycles++;
        end
        if (!line_done) begin
            $display("line_done did not arrive within %0d cycles for line %0d",
                     RENDER_LIMIT, y);
            timed_out = 1'b1;
        end
    endtask

    // pix_out follows pix_x by one clock
    task automatic check_pixel(input logic [7:0] x, input logic [7:0] expected);
        @(posedge clk_sys);
        pix_x <= x;
        @(posedge clk_sys);
        @(negedge clk_sys);
        check_value($sformatf("pix_out[%0d]", x), 32'(expected), 32'(pix_out));
    endtask

    task automatic check_list_y(input logic [7:0] expected);
        int i;
        sprite_attr_t entry;
        for (i = 0; i < SPRITE_COUNT; i++) begin
            entry = UUT.u_sprite_buf.mem[i];
            check_value($sformatf("sprite_buf[%0d].y_pos", i), 32'(expected),
                        32'(entry.y_pos));
        end
    endtask

    // ============================================================
    // record replay
    // ============================================================
    initial begin
        int          idx;
        logic [31:0] rec;

        reset        = 1'b1;
        cpu_wr       = 1'b0;
        cpu_addr     = '0;
        cpu_data     = '0;
        rom_wr       = 1'b0;
        rom_addr     = '0;
        rom_data     = '0;
        vblank_start = 1'b0;
        line_start   = 1'b0;
        line_y       = '0;
        pix_x        = '0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        for (idx = 0; idx < RECORD_MAX; idx++) begin
            records[idx] = '0;
        end
        $readmemh("sim/sprite_patterns.mem", records);

        repeat (4) @(posedge clk_sys);
        reset <= 1'b0;
        // both done strobes idle out of reset
        repeat (4) begin
            @(negedge clk_sys);
            check_value("copy_done", 32'(0), 32'(copy_done));
            check_value("line_done", 32'(0), 32'(line_done));
        end

        idx = 0;
        while (idx < RECORD_MAX && !timed_out && records[idx][31:28] != OP_END) begin
            rec = records[idx];
            case (rec[31:28])
                OP_RAM_WR:   write_shared(rec[15:8], rec[7:0]);
                OP_ROM_WR:   write_rom(rec[23:8], rec[7:0]);
                OP_CLEAR:    clear_shared();
                OP_VBLANK:   run_copy();
                OP_LINE:     run_line(rec[7:0]);
                OP_PIXEL:    check_pixel(rec[15:8], rec[7:0]);
                OP_TEST_END: finish_test(int'(rec[7:0]));
                OP_LIST_Y:   check_list_y(rec[7:0]);
                default: begin
                    $display("unknown record %h at index %0d", rec, idx);
                    test_errors++;
                end
            endcase
            idx++;
        end

        // a test cut short by a timeout counts as failed
        if (timed_out) begin
            tests_failed++;
        end
        if (tests_passed + tests_failed == 0) begin
            $display("no tests were found in the patterns file");
        end
        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0 && test_errors == 0 && !timed_out && tests_passed > 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/sprite_patterns.mem */
// word: op[31:28] 0 addr[23:8] data[7:0]; op 1 ram wr, 2 rom wr, 3 clear list, 4 vblank,
// 5 line (data = y), 6 pixel (addr = x, data = colour:pen), 7 test end, 8 all y_pos, 0 end
// tile 0x105 row 3, pen equals column
20414C10 20414D54 20414E98 20414FDC 20C14C32 20C14D76 20C14EBA 20C14FFE
// tile 0x105 row 12, pen is column plus 8
20417098 204171DC 20417210 20417354 20C170BA 20C171FE 20C17232 20C17376
// tile 0x006 row 3, pen a on odd columns only
20018CA0 20018DA0 20018EA0 20018FA0 20818CA0 20818DA0 20818EA0 20818FA0
// test 1, empty list puts every sprite at y 240 and x 384
30000000 40000000 800000F0 50000064
60000000 60008000 6000FF00
70000001
// test 2, sprite 0 raw y 40, tile 0x105, colour 3, raw x 0x90
10000028 10000105 10000232 10000390
40000000 500000CB
60001000 60001131 60001737 60001F3F 60002000
// line 216 is past the bottom row
500000D8 60001100 60001F00
70000002
// test 3, flip x then flip y
10000236 40000000 500000CB
6000103F 6000113E 60001E31 60001F00
1000023A 40000000 500000CB
60001038 6000143C 60001800 60001F37
70000003
// test 4, sprite 2 colour 5 under sprite 5 colour 9, both at y 97 x 64
1000088F 10000905 10000A52 10000BC0
1000148F 10001506 10001690 100017C0
40000000 50000064
60004000 6000419A 60004252 60004858 60004F9A 60005000
70000004
// test 5, sprite 2 at x 248, sprite 5 at x 256
10000A53 10000B78 10001691 10001780
40000000 50000064
6000F800 6000F951 6000FF57 60000000 60000100 60000700 60004100
70000005
// test 6, colour change shows only after the next copy
10000A73 50000064 6000F951
40000000 50000064 6000F971 6000FF77
70000006
00000000

/* vlog.f */
design/sprite_geom_pkg.sv
design/sprite_mem_pkg.sv
design/sprite_ram.sv
design/sprite_list_copy.sv
design/sprite_line_render.sv
design/sprite_engine.sv
sim/tb_sprite_engine.sv

/* Makefile */
# Verilator build and run of the sprite engine testbench

SIM := obj_dir/Vtb_sprite_engine

.PHONY: all run clean

all: run

# rebuilt only when the file list or a source in it changes
$(SIM): vlog.f $(shell cat vlog.f)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_sprite_engine -f vlog.f

# the run fails unless the pass message shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
